//--- rtl/ptw_defines.svh
`ifndef PTW_DEFINES_SVH
`define PTW_DEFINES_SVH

// ----------------------------------------
// sv39 address geometry
// ----------------------------------------

// virtual address width, three 9-bit vpn slices plus page offset
`define PTW_VLEN 39
// physical address width on the memory port
`define PTW_PLEN 56
// physical page number width, as held in satp and in a pte
`define PTW_PPNW 44
// address space identifier
`define PTW_ASIDW 16
// one vpn slice, indexes 512 ptes of a table
`define PTW_VPNW 9
// 4k page offset
`define PTW_PGOFFW 12

// ----------------------------------------
// pte layout
// ----------------------------------------

// one page-table entry
`define PTW_PTEW 64
// ptes are 8 bytes, so the table index is shifted by 3
`define PTW_PTE_SHIFT 3
// position of the g flag inside the pte
`define PTW_G_BIT 5

`endif

//--- rtl/ptw_miss_arbiter.sv
`timescale 1ns/1ps
`include "ptw_defines.svh"

module ptw_miss_arbiter (
  input  logic                      enable_translation_i,
  input  logic                      en_ld_st_translation_i,
  input  logic                      itlb_access_i,
  input  logic                      itlb_hit_i,
  input  logic [`PTW_VLEN-1:0]      itlb_vaddr_i,
  input  logic                      dtlb_access_i,
  input  logic                      dtlb_hit_i,
  input  logic [`PTW_VLEN-1:0]      dtlb_vaddr_i,
  input  logic [`PTW_PPNW-1:0]      satp_ppn_i,
  input  logic [`PTW_ASIDW-1:0]     asid_i,
  input  logic                      walk_idle_i,
  output ptw_pkg::miss_req_t        miss_o,
  output logic                      itlb_miss_o,
  output logic                      dtlb_miss_o
);

  logic                 dtlb_sel;
  logic                 itlb_sel;
  logic [`PTW_VLEN-1:0] sel_vaddr;

  // data side wins whenever it is accessing
  assign dtlb_sel = en_ld_st_translation_i & dtlb_access_i & ~dtlb_hit_i;
  // fetch miss only when the lsu is not touching its tlb at all
  assign itlb_sel = enable_translation_i & itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;

  assign sel_vaddr = dtlb_sel ? dtlb_vaddr_i : itlb_vaddr_i;

  // ----------------------------------------
  // miss request
  // ----------------------------------------
  always_comb begin
    miss_o.valid    = dtlb_sel | itlb_sel;
    miss_o.is_instr = itlb_sel;
    miss_o.vaddr    = sel_vaddr;
    // root table base plus vpn[2] index, ptes are 8 bytes
    miss_o.root     = {satp_ppn_i,
                       sel_vaddr[`PTW_VLEN-1:`PTW_VLEN-`PTW_VPNW],
                       {`PTW_PTE_SHIFT{1'b0}}};
    miss_o.asid     = asid_i;
  end

  // perf pulses, only for misses the walker accepts this cycle
  assign itlb_miss_o = itlb_sel & walk_idle_i;
  assign dtlb_miss_o = dtlb_sel & walk_idle_i;

endmodule

//--- rtl/ptw_pkg.sv
`include "ptw_defines.svh"

package ptw_pkg;

  // ----------------------------------------
  // page-table entry
  // ----------------------------------------
  typedef struct packed {
    logic [9:0]              reserved;
    logic [`PTW_PPNW-1:0]    ppn;
    // free for software use
    logic [1:0]              rsw;
    logic                    d;
    logic                    a;
    logic                    g;
    logic                    u;
    logic                    x;
    logic                    w;
    logic                    r;
    logic                    v;
  } pte_t;

  // walker states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    WAIT_RVALID,
    PROPAGATE_ERROR
  } ptw_state_e;

  // table level, LVL1 maps 1G, LVL2 maps 2M, LVL3 maps 4K
  typedef enum logic [1:0] {
    LVL1,
    LVL2,
    LVL3
  } ptw_lvl_e;

  // ----------------------------------------
  // block-to-block bundles
  // ----------------------------------------

  // the miss selected to start a walk
  typedef struct packed {
    logic                    valid;
    logic                    is_instr;
    logic [`PTW_VLEN-1:0]    vaddr;
    logic [`PTW_PLEN-1:0]    root;
    logic [`PTW_ASIDW-1:0]   asid;
  } miss_req_t;

  // result of checking one fetched pte
  typedef struct packed {
    logic                    is_leaf;
    logic                    fault;
    logic                    update_ok;
  } pte_verdict_t;

  // tlb fill, vpn is vaddr[38:12]
  typedef struct packed {
    logic                                 valid;
    logic                                 is_2m;
    logic                                 is_1g;
    logic [`PTW_VLEN-`PTW_PGOFFW-1:0]     vpn;
    logic [`PTW_ASIDW-1:0]                asid;
    pte_t                                 content;
  } tlb_update_t;

  // read-only memory port
  typedef struct packed {
    logic                    req;
    logic [`PTW_PLEN-1:0]    addr;
  } mem_req_t;

  typedef struct packed {
    logic                    gnt;
    logic                    rvalid;
    logic [`PTW_PTEW-1:0]    rdata;
  } mem_rsp_t;

endpackage

//--- rtl/ptw_pte_check.sv
`timescale 1ns/1ps
`include "ptw_defines.svh"

module ptw_pte_check (
  input  ptw_pkg::pte_t          pte_i,
  input  ptw_pkg::ptw_lvl_e      lvl_i,
  input  logic                   is_instr_i,
  input  logic                   is_store_i,
  input  logic                   mxr_i,
  output ptw_pkg::pte_verdict_t  verdict_o
);

  logic is_leaf;
  logic bad_encoding;
  logic bad_pointer;
  logic misaligned;
  logic instr_denied;
  logic data_denied;
  logic store_denied;
  logic leaf_fault;
  logic fault;

  // r or x marks a leaf, otherwise it points to the next table
  assign is_leaf = pte_i.r | pte_i.x;

  // ----------------------------------------
  // encoding checks, any pte
  // ----------------------------------------
  // invalid, write-only or reserved bits in use
  assign bad_encoding = ~pte_i.v
                      | (~pte_i.r & pte_i.w)
                      | (|pte_i.reserved);

  // pointer with leaf-only flags, or no table below LVL3
  assign bad_pointer = ~is_leaf
                     & (pte_i.a | pte_i.d | pte_i.u | (lvl_i == ptw_pkg::LVL3));

  // ----------------------------------------
  // leaf checks
  // ----------------------------------------
  // superpage ppn must be aligned to its own size
  assign misaligned =
      ((lvl_i == ptw_pkg::LVL1) & (|pte_i.ppn[2*`PTW_VPNW-1:0]))
    | ((lvl_i == ptw_pkg::LVL2) & (|pte_i.ppn[`PTW_VPNW-1:0]));

  // fetch needs x, and a is managed by software
  assign instr_denied = is_instr_i & (~pte_i.x | ~pte_i.a);

  // loads need r, or x when mxr makes executable pages readable
  assign data_denied = ~is_instr_i
                     & (~pte_i.a | ~(pte_i.r | (pte_i.x & mxr_i)));

  // stores also need w and an already set d
  assign store_denied = ~is_instr_i & is_store_i & (~pte_i.w | ~pte_i.d);

  assign leaf_fault = is_leaf & (misaligned | instr_denied | data_denied | store_denied);

  assign fault = bad_encoding | bad_pointer | leaf_fault;

  always_comb begin
    verdict_o.is_leaf   = is_leaf;
    verdict_o.fault     = fault;
    // a clean leaf can go straight into the tlb
    verdict_o.update_ok = is_leaf & ~fault;
  end

endmodule

//--- rtl/ptw_top.sv
`timescale 1ns/1ps
`include "ptw_defines.svh"

module ptw_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  input  logic                      lsu_is_store_i,
  input  logic                      mxr_i,
  input  logic                      enable_translation_i,
  input  logic                      en_ld_st_translation_i,
  input  logic                      itlb_access_i,
  input  logic                      itlb_hit_i,
  input  logic                      dtlb_access_i,
  input  logic                      dtlb_hit_i,
  input  logic [`PTW_VLEN-1:0]      itlb_vaddr_i,
  input  logic [`PTW_VLEN-1:0]      dtlb_vaddr_i,
  input  logic [`PTW_PPNW-1:0]      satp_ppn_i,
  input  logic [`PTW_ASIDW-1:0]     asid_i,
  input  ptw_pkg::mem_rsp_t         mem_rsp_i,
  output ptw_pkg::mem_req_t         mem_req_o,
  output ptw_pkg::tlb_update_t      itlb_update_o,
  output ptw_pkg::tlb_update_t      dtlb_update_o,
  output logic [`PTW_VLEN-1:0]      update_vaddr_o,
  output logic                      ptw_active_o,
  output logic                      walking_instr_o,
  output logic                      ptw_error_o,
  output logic                      itlb_miss_o,
  output logic                      dtlb_miss_o
);

  ptw_pkg::miss_req_t     miss;
  ptw_pkg::pte_verdict_t  verdict;
  ptw_pkg::pte_t          pte;
  ptw_pkg::ptw_lvl_e      lvl;
  logic                   walk_idle;
  logic                   is_instr;
  logic                   is_store;

  // ----------------------------------------
  // miss selection
  // ----------------------------------------
  ptw_miss_arbiter ptw_miss_arbiter_i (
    .enable_translation_i   (enable_translation_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .itlb_access_i          (itlb_access_i),
    .itlb_hit_i             (itlb_hit_i),
    .itlb_vaddr_i           (itlb_vaddr_i),
    .dtlb_access_i          (dtlb_access_i),
    .dtlb_hit_i             (dtlb_hit_i),
    .dtlb_vaddr_i           (dtlb_vaddr_i),
    .satp_ppn_i             (satp_ppn_i),
    .asid_i                 (asid_i),
    .walk_idle_i            (walk_idle),
    .miss_o                 (miss),
    .itlb_miss_o            (itlb_miss_o),
    .dtlb_miss_o            (dtlb_miss_o)
  );

  // walk sequencing and memory port
  ptw_walk_fsm ptw_walk_fsm_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .lsu_is_store_i  (lsu_is_store_i),
    .miss_i          (miss),
    .mem_rsp_i       (mem_rsp_i),
    .verdict_i       (verdict),
    .walk_idle_o     (walk_idle),
    .mem_req_o       (mem_req_o),
    .pte_o           (pte),
    .lvl_o           (lvl),
    .is_instr_o      (is_instr),
    .is_store_o      (is_store),
    .itlb_update_o   (itlb_update_o),
    .dtlb_update_o   (dtlb_update_o),
    .update_vaddr_o  (update_vaddr_o),
    .ptw_active_o    (ptw_active_o),
    .walking_instr_o (walking_instr_o),
    .ptw_error_o     (ptw_error_o)
  );

  // pte checks on the registered reply
  ptw_pte_check ptw_pte_check_i (
    .pte_i      (pte),
    .lvl_i      (lvl),
    .is_instr_i (is_instr),
    .is_store_i (is_store),
    .mxr_i      (mxr_i),
    .verdict_o  (verdict)
  );

endmodule

//--- rtl/ptw_walk_fsm.sv
`timescale 1ns/1ps
`include "ptw_defines.svh"

module ptw_walk_fsm (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  input  logic                      lsu_is_store_i,
  input  ptw_pkg::miss_req_t        miss_i,
  input  ptw_pkg::mem_rsp_t         mem_rsp_i,
  input  ptw_pkg::pte_verdict_t     verdict_i,
  output logic                      walk_idle_o,
  output ptw_pkg::mem_req_t         mem_req_o,
  output ptw_pkg::pte_t             pte_o,
  output ptw_pkg::ptw_lvl_e         lvl_o,
  output logic                      is_instr_o,
  output logic                      is_store_o,
  output ptw_pkg::tlb_update_t      itlb_update_o,
  output ptw_pkg::tlb_update_t      dtlb_update_o,
  output logic [`PTW_VLEN-1:0]      update_vaddr_o,
  output logic                      ptw_active_o,
  output logic                      walking_instr_o,
  output logic                      ptw_error_o
);

  ptw_pkg::ptw_state_e     state_q, state_d;
  ptw_pkg::ptw_lvl_e       lvl_q, lvl_d;
  logic                    is_instr_q, is_instr_d;
  logic                    is_store_q, is_store_d;
  // sticky g seen on any level of this walk
  logic                    global_q, global_d;
  logic [`PTW_PLEN-1:0]    pptr_q, pptr_d;
  logic [`PTW_VLEN-1:0]    vaddr_q, vaddr_d;
  logic [`PTW_ASIDW-1:0]   asid_q, asid_d;
  // memory reply, registered once before use
  logic                    rvalid_q;
  logic [`PTW_PTEW-1:0]    rdata_q;
  logic                    upd_valid;
  logic [`PTW_PTEW-1:0]    g_mask;
  ptw_pkg::tlb_update_t    upd;

  // a flush in IDLE blocks a new walk from starting
  assign walk_idle_o     = (state_q == ptw_pkg::IDLE) & ~flush_i;
  assign ptw_active_o    = (state_q != ptw_pkg::IDLE);
  assign walking_instr_o = is_instr_q;
  assign update_vaddr_o  = vaddr_q;

  // to the checker
  assign pte_o      = ptw_pkg::pte_t'(rdata_q);
  assign lvl_o      = lvl_q;
  assign is_instr_o = is_instr_q;
  assign is_store_o = is_store_q;

  // ----------------------------------------
  // walk state machine
  // ----------------------------------------
  always_comb begin
    state_d       = state_q;
    lvl_d         = lvl_q;
    is_instr_d    = is_instr_q;
    is_store_d    = is_store_q;
    global_d      = global_q;
    pptr_d        = pptr_q;
    vaddr_d       = vaddr_q;
    asid_d        = asid_q;
    upd_valid     = 1'b0;
    ptw_error_o   = 1'b0;
    mem_req_o.req  = 1'b0;
    // address is held for the whole walk step
    mem_req_o.addr = pptr_q;

    case (state_q)
      ptw_pkg::IDLE: begin
        // every walk starts from the root table
        lvl_d      = ptw_pkg::LVL1;
        global_d   = 1'b0;
        is_instr_d = 1'b0;
        is_store_d = 1'b0;
        if (miss_i.valid && walk_idle_o) begin
          state_d    = ptw_pkg::WAIT_GRANT;
          is_instr_d = miss_i.is_instr;
          // store qualifier only matters for data walks
          is_store_d = lsu_is_store_i & ~miss_i.is_instr;
          pptr_d     = miss_i.root;
          vaddr_d    = miss_i.vaddr;
          asid_d     = miss_i.asid;
        end
      end

      ptw_pkg::WAIT_GRANT: begin
        mem_req_o.req = 1'b1;
        if (mem_rsp_i.gnt) begin
          state_d = ptw_pkg::PTE_LOOKUP;
        end
      end

      ptw_pkg::PTE_LOOKUP: begin
        if (rvalid_q) begin
          if (pte_o.g) begin
            global_d = 1'b1;
          end
          if (verdict_i.fault) begin
            state_d = ptw_pkg::PROPAGATE_ERROR;
          end else if (verdict_i.update_ok) begin
            // leaf found, fill the tlb this cycle
            upd_valid = ~flush_i;
            state_d   = ptw_pkg::IDLE;
          end else if (!verdict_i.is_leaf) begin
            // pointer, descend one level with the next vpn slice
            state_d = ptw_pkg::WAIT_GRANT;
            case (lvl_q)
              ptw_pkg::LVL1: begin
                lvl_d  = ptw_pkg::LVL2;
                pptr_d = {pte_o.ppn,
                          vaddr_q[`PTW_PGOFFW+2*`PTW_VPNW-1:`PTW_PGOFFW+`PTW_VPNW],
                          {`PTW_PTE_SHIFT{1'b0}}};
              end
              ptw_pkg::LVL2: begin
                lvl_d  = ptw_pkg::LVL3;
                pptr_d = {pte_o.ppn,
                          vaddr_q[`PTW_PGOFFW+`PTW_VPNW-1:`PTW_PGOFFW],
                          {`PTW_PTE_SHIFT{1'b0}}};
              end
              default: begin
                // pointer at LVL3 is caught by the checker
                lvl_d = lvl_q;
              end
            endcase
          end
        end
      end

      ptw_pkg::PROPAGATE_ERROR: begin
        state_d     = ptw_pkg::IDLE;
        ptw_error_o = ~flush_i;
      end

      // drain the reply of a flushed request
      ptw_pkg::WAIT_RVALID: begin
        if (rvalid_q) begin
          state_d = ptw_pkg::IDLE;
        end
      end

      default: begin
        state_d = ptw_pkg::IDLE;
      end
    endcase

    // ----------------------------------------
    // flush
    // ----------------------------------------
    // a request already granted still owes a reply, wait for it
    if (flush_i) begin
      if ((state_q == ptw_pkg::PTE_LOOKUP && !rvalid_q) ||
          (state_q == ptw_pkg::WAIT_GRANT && mem_rsp_i.gnt)) begin
        state_d = ptw_pkg::WAIT_RVALID;
      end else begin
        state_d = ptw_pkg::IDLE;
      end
    end
  end

  // ----------------------------------------
  // tlb update
  // ----------------------------------------
  always_comb begin
    g_mask             = '0;
    g_mask[`PTW_G_BIT] = global_q;
    upd.valid   = 1'b0;
    upd.is_2m   = (lvl_q == ptw_pkg::LVL2);
    upd.is_1g   = (lvl_q == ptw_pkg::LVL1);
    upd.vpn     = vaddr_q[`PTW_VLEN-1:`PTW_PGOFFW];
    upd.asid    = asid_q;
    // g from any upper level makes the whole mapping global
    upd.content = ptw_pkg::pte_t'(rdata_q | g_mask);

    itlb_update_o       = upd;
    itlb_update_o.valid = upd_valid & is_instr_q;
    dtlb_update_o       = upd;
    dtlb_update_o.valid = upd_valid & ~is_instr_q;
  end

  // control state
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ptw_pkg::IDLE;
      lvl_q      <= ptw_pkg::LVL1;
      is_instr_q <= 1'b0;
      is_store_q <= 1'b0;
      global_q   <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      state_q    <= state_d;
      lvl_q      <= lvl_d;
      is_instr_q <= is_instr_d;
      is_store_q <= is_store_d;
      global_q   <= global_d;
      rvalid_q   <= mem_rsp_i.rvalid;
    end
  end

  // walk payload
  always_ff @(posedge clk_i) begin
    pptr_q  <= pptr_d;
    vaddr_q <= vaddr_d;
    asid_q  <= asid_d;
    rdata_q <= mem_rsp_i.rdata;
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the page-table walker testbench with Verilator
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  -f vlog.f --top-module ptw_tb -o ptw_sim > build.log 2>&1 &&
  ./obj_dir/ptw_sim > sim.log 2>&1 ||
  { echo "build or run error, see build.log and sim.log"; exit 1; }
cat sim.log
# the verdict comes from the simulation log
grep -q "Simulation PASSED" sim.log && echo "run ok" ||
  { echo "run failed"; exit 1; }

//--- test/ptw_tb.sv
`timescale 1ns/1ps
`include "ptw_defines.svh"

module ptw_tb;

  // ----------------------------------------
  // constants
  // ----------------------------------------
  localparam int num_tests   = 18;
  // cycle budget per walk that also scales the watchdog
  localparam int walk_cycles = 200;

  localparam logic [`PTW_PPNW-1:0] root_ppn = 44'h80000;
  localparam logic [`PTW_PPNW-1:0] l2_ppn   = 44'h80001;
  localparam logic [`PTW_PPNW-1:0] l3_ppn   = 44'h80002;
  localparam logic [`PTW_PPNW-1:0] mid_ppn  = 44'h80003;
  localparam logic [`PTW_PPNW-1:0] g2_ppn   = 44'h80004;
  localparam logic [`PTW_PPNW-1:0] g3_ppn   = 44'h80005;

  // pte flags in d a g u x w r v order
  localparam logic [7:0] flag_v = 8'h01;
  localparam logic [7:0] flag_r = 8'h02;
  localparam logic [7:0] flag_w = 8'h04;
  localparam logic [7:0] flag_x = 8'h08;
  localparam logic [7:0] flag_g = 8'h20;
  localparam logic [7:0] flag_a = 8'h40;
  localparam logic [7:0] flag_d = 8'h80;

  // one predicted walk result
  typedef struct packed {
    logic                  err;
    logic                  is_instr;
    logic [`PTW_VLEN-1:0]  va;
    ptw_pkg::tlb_update_t  upd;
  } expect_t;

  logic                    clk_i = 1'b0;
  logic                    rst_n_i;
  logic                    flush_i;
  logic                    lsu_is_store_i;
  logic                    mxr_i;
  logic                    enable_translation_i;
  logic                    en_ld_st_translation_i;
  logic                    itlb_access_i;
  logic                    itlb_hit_i;
  logic                    dtlb_access_i;
  logic                    dtlb_hit_i;
  logic [`PTW_VLEN-1:0]    itlb_vaddr_i;
  logic [`PTW_VLEN-1:0]    dtlb_vaddr_i;
  logic [`PTW_PPNW-1:0]    satp_ppn_i;
  logic [`PTW_ASIDW-1:0]   asid_i;
  ptw_pkg::mem_rsp_t       mem_rsp_i = '0;
  ptw_pkg::mem_req_t       mem_req_o;
  ptw_pkg::tlb_update_t    itlb_update_o;
  ptw_pkg::tlb_update_t    dtlb_update_o;
  logic [`PTW_VLEN-1:0]    update_vaddr_o;
  logic                    ptw_active_o;
  logic                    walking_instr_o;
  logic                    ptw_error_o;
  logic                    itlb_miss_o;
  logic                    dtlb_miss_o;

  // sparse page tables keyed by physical address
  logic [`PTW_PTEW-1:0]    mem [logic [`PTW_PLEN-1:0]];
  integer                  seed = 2363;
  int                      gnt_cnt = -1;
  int                      rsp_cnt = 0;
  logic [`PTW_PLEN-1:0]    rsp_addr;
  // results still owed by the walker with the oldest at the front
  expect_t                 exp_q[$];
  string                   name_q[$];
  string                   test_name = "reset";
  int                      errors = 0;
  int                      checks = 0;
  int                      itlb_misses = 0;
  int                      dtlb_misses = 0;

  ptw_top ptw_top_i (.*);

  initial begin
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [`PTW_VLEN-1:0] make_va(input logic [8:0] vpn2, vpn1, vpn0,
                                                   input logic [11:0] off);
    return {vpn2, vpn1, vpn0, off};
  endfunction

  function automatic ptw_pkg::pte_t make_pte(input logic [`PTW_PPNW-1:0] ppn,
                                             input logic [7:0] flags);
    ptw_pkg::pte_t p;
    p     = '0;
    p.ppn = ppn;
    {p.d, p.a, p.g, p.u, p.x, p.w, p.r, p.v} = flags;
    return p;
  endfunction

  task automatic put_pte(input logic [`PTW_PPNW-1:0] table_ppn, input logic [8:0] idx,
                         input ptw_pkg::pte_t p);
    mem[{table_ppn, idx, 3'b000}] = p;
  endtask

  // unmapped addresses read as an invalid pte
  function automatic logic [`PTW_PTEW-1:0] read_pte(input logic [`PTW_PLEN-1:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return '0;
  endfunction

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  // ----------------------------------------
  // reference sv39 walk
  // ----------------------------------------
  function automatic expect_t ref_walk(input logic instr, input logic store, input logic mxr,
                                       input logic [`PTW_VLEN-1:0] va);
    expect_t               e;
    ptw_pkg::pte_t         p;
    logic [`PTW_PLEN-1:0]  a;
    logic                  glob;
    logic                  leaf;
    logic                  bad;
    logic                  done;
    int                    lvl;
    e          = '0;
    e.is_instr = instr;
    e.va       = va;
    glob       = 1'b0;
    done       = 1'b0;
    a          = {satp_ppn_i, va[38:30], 3'b000};
    for (lvl = 0; lvl < 3; lvl++) begin
      if (!done) begin
        p    = read_pte(a);
        glob = glob | p.g;
        leaf = p.r | p.x;
        bad  = !p.v || (p.w && !p.r) || (p.reserved != '0);
        if (!leaf) begin
          // pointers carry no a d u and none sit below the 4k level
          bad = bad || p.a || p.d || p.u || (lvl == 2);
        end else begin
          if (lvl == 0 && p.ppn[17:0] != '0) bad = 1'b1;
          if (lvl == 1 && p.ppn[8:0] != '0) bad = 1'b1;
          if (instr) begin
            bad = bad || !p.x || !p.a;
          end else begin
            bad = bad || !p.a || !(p.r || (p.x && mxr));
            if (store) bad = bad || !p.w || !p.d;
          end
        end
        if (bad) begin
          e.err = 1'b1;
          done  = 1'b1;
        end else if (leaf) begin
          e.upd.valid     = 1'b1;
          e.upd.is_1g     = (lvl == 0);
          e.upd.is_2m     = (lvl == 1);
          e.upd.vpn       = va[38:12];
          e.upd.asid      = asid_i;
          e.upd.content   = p;
          // g on any level covers the whole mapping
          e.upd.content.g = glob;
          done            = 1'b1;
        end else begin
          a = {p.ppn, va[29 - 9*lvl -: 9], 3'b000};
        end
      end
    end
    return e;
  endfunction

  // ----------------------------------------
  // memory model with grant after 0 to 3 cycles and reply 1 to 4 cycles later
  // ----------------------------------------
  always @(negedge clk_i) begin
    mem_rsp_i.gnt    = 1'b0;
    mem_rsp_i.rvalid = 1'b0;
    if (rsp_cnt > 0) begin
      rsp_cnt = rsp_cnt - 1;
      if (rsp_cnt == 0) begin
        mem_rsp_i.rvalid = 1'b1;
        mem_rsp_i.rdata  = read_pte(rsp_addr);
      end
    end else if (mem_req_o.req) begin
      if (gnt_cnt < 0) begin
        gnt_cnt = $unsigned($random(seed)) % 4;
      end
      if (gnt_cnt == 0) begin
        mem_rsp_i.gnt = 1'b1;
        rsp_addr      = mem_req_o.addr;
        rsp_cnt       = 1 + $unsigned($random(seed)) % 4;
        gnt_cnt       = -1;
      end else begin
        gnt_cnt = gnt_cnt - 1;
      end
    end else begin
      // request withdrawn by a flush
      gnt_cnt = -1;
    end
  end

  // ----------------------------------------
  // compare process
  // ----------------------------------------
  always @(posedge clk_i) begin : compare
    expect_t e;
    string   n;
    if (itlb_miss_o) itlb_misses++;
    if (dtlb_miss_o) dtlb_misses++;
    if (ptw_active_o && exp_q.size() != 0) begin
      e = exp_q[0];
      check_value({name_q[0], " walking_instr"}, 128'(e.is_instr), 128'(walking_instr_o));
    end
    if (rst_n_i && (ptw_error_o || itlb_update_o.valid || dtlb_update_o.valid)) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("walker gave a result although none was expected, test %s", test_name);
      end else begin
        e = exp_q.pop_front();
        n = name_q.pop_front();
        check_value({n, " result"},
                    128'({e.err, ~e.err & e.is_instr, ~e.err & ~e.is_instr}),
                    128'({ptw_error_o, itlb_update_o.valid, dtlb_update_o.valid}));
        check_value({n, " vaddr"}, 128'(e.va), 128'(update_vaddr_o));
        if (!e.err) begin
          check_value({n, " update"}, 128'(e.upd),
                      128'(e.is_instr ? itlb_update_o : dtlb_update_o));
        end
      end
    end
  end

  // ----------------------------------------
  // stimulus tasks run on the falling edge
  // ----------------------------------------
  task automatic expect_walk(input string name, input logic instr, input logic store,
                             input logic mxr, input logic [`PTW_VLEN-1:0] va);
    test_name      = name;
    lsu_is_store_i = store;
    mxr_i          = mxr;
    exp_q.push_back(ref_walk(instr, store, mxr, va));
    name_q.push_back(name);
  endtask

  // raise a miss and hold it until the walker takes it
  task automatic start_miss(input logic instr, input logic [`PTW_VLEN-1:0] va);
    int n;
    int c;
    n = instr ? itlb_misses : dtlb_misses;
    c = 0;
    if (instr) begin
      itlb_vaddr_i  = va;
      itlb_access_i = 1'b1;
    end else begin
      dtlb_vaddr_i  = va;
      dtlb_access_i = 1'b1;
    end
    while (((instr ? itlb_misses : dtlb_misses) == n) && c < walk_cycles) begin
      @(negedge clk_i);
      c++;
    end
    if (instr) itlb_access_i = 1'b0;
    else dtlb_access_i = 1'b0;
    if (c == walk_cycles) begin
      errors++;
      $display("miss was never accepted by the walker, test %s", test_name);
    end
  endtask

  task automatic wait_results();
    int c;
    c = 0;
    while (exp_q.size() != 0 && c < walk_cycles) begin
      @(negedge clk_i);
      c++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("walker never finished the walk, test %s", test_name);
      exp_q.delete();
      name_q.delete();
    end
  endtask

  task automatic run_walk(input string name, input logic instr, input logic store,
                          input logic mxr, input logic [`PTW_VLEN-1:0] va);
    expect_walk(name, instr, store, mxr, va);
    start_miss(instr, va);
    wait_results();
  endtask

  // walk flushed in WAIT_GRANT or in PTE_LOOKUP must give no result
  task automatic flush_walk(input string name, input logic in_lookup,
                            input logic [`PTW_VLEN-1:0] va);
    int c;
    test_name = name;
    start_miss(1'b1, va);
    c = 0;
    // request gone while still active means the grant was taken
    while (in_lookup && mem_req_o.req && c < walk_cycles) begin
      @(negedge clk_i);
      c++;
    end
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    c = 0;
    while (ptw_active_o && c < walk_cycles) begin
      @(negedge clk_i);
      c++;
    end
    if (ptw_active_o) begin
      errors++;
      $display("ptw_active_o stayed high after the flush, test %s", name);
    end
  endtask

  task automatic build_tables();
    ptw_pkg::pte_t p;
    // 4k path root[1] -> l2[2] -> l3[n]
    put_pte(root_ppn, 9'd1, make_pte(l2_ppn, flag_v));
    put_pte(l2_ppn, 9'd2, make_pte(l3_ppn, flag_v));
    put_pte(l3_ppn, 9'd3, make_pte(44'h12345, flag_v | flag_r | flag_x | flag_a));
    // readable but not executable
    put_pte(l3_ppn, 9'd4, make_pte(44'h12346, flag_v | flag_r | flag_a));
    // writable with d still clear
    put_pte(l3_ppn, 9'd5, make_pte(44'h12347, flag_v | flag_r | flag_w | flag_a));
    // execute only
    put_pte(l3_ppn, 9'd6, make_pte(44'h12348, flag_v | flag_x | flag_a));
    // aligned and misaligned superpages
    put_pte(root_ppn, 9'd4, make_pte(44'h40000, flag_v | flag_r | flag_w | flag_a | flag_d));
    put_pte(root_ppn, 9'd5, make_pte(mid_ppn, flag_v));
    put_pte(mid_ppn, 9'd6, make_pte(44'h00200, flag_v | flag_r | flag_a));
    put_pte(root_ppn, 9'd7, make_pte(44'h40001, flag_v | flag_r | flag_a));
    put_pte(mid_ppn, 9'd8, make_pte(44'h00201, flag_v | flag_r | flag_a));
    // root[9] stays unmapped and reads as invalid
    p          = make_pte(44'hc0000, flag_v | flag_r | flag_a);
    p.reserved = 10'h001;
    put_pte(root_ppn, 9'd10, p);
    // global flag only on the top pointer
    put_pte(root_ppn, 9'd11, make_pte(g2_ppn, flag_v | flag_g));
    put_pte(g2_ppn, 9'd0, make_pte(g3_ppn, flag_v));
    put_pte(g3_ppn, 9'd1, make_pte(44'h23456, flag_v | flag_r | flag_w | flag_a | flag_d));
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin : main
    logic [`PTW_VLEN-1:0] va_4k;
    logic [`PTW_VLEN-1:0] va_1g;
    int                   itlb_before;
    rst_n_i                = 1'b0;
    flush_i                = 1'b0;
    lsu_is_store_i         = 1'b0;
    mxr_i                  = 1'b0;
    enable_translation_i   = 1'b1;
    en_ld_st_translation_i = 1'b1;
    itlb_access_i          = 1'b0;
    itlb_hit_i             = 1'b0;
    dtlb_access_i          = 1'b0;
    dtlb_hit_i             = 1'b0;
    itlb_vaddr_i           = '0;
    dtlb_vaddr_i           = '0;
    satp_ppn_i             = root_ppn;
    asid_i                 = 16'h005a;
    va_4k                  = make_va(9'd1, 9'd2, 9'd3, 12'h123);
    va_1g                  = make_va(9'd4, 9'h155, 9'h0aa, 12'h010);
    build_tables();
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    // req, update valids, error, miss pulses, active
    check_value("reset_idle", 128'd0,
                128'({mem_req_o.req, itlb_update_o.valid, dtlb_update_o.valid, ptw_error_o,
                      itlb_miss_o, dtlb_miss_o, ptw_active_o}));

    run_walk("itlb_4k", 1'b1, 1'b0, 1'b0, va_4k);
    run_walk("dtlb_1g", 1'b0, 1'b0, 1'b0, va_1g);
    run_walk("dtlb_2m", 1'b0, 1'b0, 1'b0, make_va(9'd5, 9'd6, 9'h033, 12'h0));
    run_walk("dtlb_1g_misaligned", 1'b0, 1'b0, 1'b0, make_va(9'd7, 9'd1, 9'd1, 12'h0));
    run_walk("dtlb_2m_misaligned", 1'b0, 1'b0, 1'b0, make_va(9'd5, 9'd8, 9'd1, 12'h0));
    run_walk("invalid_pte", 1'b0, 1'b0, 1'b0, make_va(9'd9, 9'd0, 9'd0, 12'h0));
    run_walk("reserved_bits", 1'b0, 1'b0, 1'b0, make_va(9'd10, 9'd0, 9'd0, 12'h0));
    run_walk("no_exec", 1'b1, 1'b0, 1'b0, make_va(9'd1, 9'd2, 9'd4, 12'h0));
    run_walk("store_no_dirty", 1'b0, 1'b1, 1'b0, make_va(9'd1, 9'd2, 9'd5, 12'h0));
    run_walk("exec_only_load", 1'b0, 1'b0, 1'b0, make_va(9'd1, 9'd2, 9'd6, 12'h0));
    run_walk("exec_only_mxr", 1'b0, 1'b0, 1'b1, make_va(9'd1, 9'd2, 9'd6, 12'h0));

    // both tlbs miss together and the data side goes first
    expect_walk("both_dtlb", 1'b0, 1'b0, 1'b0, va_1g);
    expect_walk("both_itlb", 1'b1, 1'b0, 1'b0, va_4k);
    itlb_before   = itlb_misses;
    itlb_vaddr_i  = va_4k;
    itlb_access_i = 1'b1;
    start_miss(1'b0, va_1g);
    check_value("both_itlb_held", 128'(itlb_before), 128'(itlb_misses));
    start_miss(1'b1, va_4k);
    wait_results();

    run_walk("global_store", 1'b0, 1'b1, 1'b0, make_va(9'd11, 9'd0, 9'd1, 12'h7f8));

    flush_walk("flush_grant", 1'b0, va_4k);
    run_walk("after_flush_grant", 1'b1, 1'b0, 1'b0, va_4k);
    flush_walk("flush_lookup", 1'b1, va_4k);
    run_walk("after_flush_lookup", 1'b0, 1'b0, 1'b0, make_va(9'd5, 9'd6, 9'h011, 12'h0));

    repeat (5) @(negedge clk_i);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog sized from the number of walks
  initial begin
    repeat (num_tests * walk_cycles) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, test %s, errors %0d",
             num_tests * walk_cycles, test_name, errors);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+rtl
rtl/ptw_pkg.sv
rtl/ptw_miss_arbiter.sv
rtl/ptw_pte_check.sv
rtl/ptw_walk_fsm.sv
rtl/ptw_top.sv
test/ptw_tb.sv
